/* include/proc_consts.svh */
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// datapath and address width
`define WORD_W 32

// register number width
`define REG_ADDR_W 5

// instruction field widths
`define OPCODE_W 5
`define ALUOP_W 5

// i-type immediate sits in the low bits of the word
`define IMM_W 17

// j-type target field in the low bits
`define TARGET_W 27

// jal destination
`define REG_LINK 31

`endif

/* hdl/proc_pkg.sv */
`include "proc_consts.svh"

package proc_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_jal   = 5'b00011,
        op_jr    = 5'b00100,
        op_addi  = 5'b00101,
        op_blt   = 5'b00110,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_e;

    typedef enum logic [`ALUOP_W-1:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_e;

    // r-type layout; i-type and j-type reuse the low bits as imm or target
    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [4:0]             shamt;
        logic [`ALUOP_W-1:0]    aluop;   // raw bits so imm words stay legal
        logic [1:0]             unused;
    } instr_t;

    typedef struct packed {
        instr_t             instr;
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] link;     // pc + 1
    } fd_t;

    typedef struct packed {
        instr_t             instr;
        logic [`WORD_W-1:0] pc;
        logic [`WORD_W-1:0] link;
        logic [`WORD_W-1:0] a_val;    // rs or rd for jr
        logic [`WORD_W-1:0] b_val;    // rt or rd for sw and branches
    } dx_t;

    typedef struct packed {
        instr_t             instr;
        logic [`WORD_W-1:0] result;   // alu out or jal link
        logic [`WORD_W-1:0] store_data;
    } xm_t;

    // register write port and bypass source
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`WORD_W-1:0]     data;
    } rf_write_t;

    typedef struct packed {
        logic [`WORD_W-1:0] addr;
        logic [`WORD_W-1:0] data;
        logic               wren;
    } dmem_req_t;

    typedef struct packed {
        logic               valid;
        logic [`WORD_W-1:0] target;
    } redirect_t;

    // never true for r0 so no consumer has to check it
    function automatic logic writes_rf(instr_t i);
        case (i.opcode)
            op_rtype, op_addi, op_lw: return i.rd != '0;
            op_jal:                   return 1'b1;
            default:                  return 1'b0;
        endcase
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] dest_reg(instr_t i);
        return (i.opcode == op_jal) ? `REG_ADDR_W'(`REG_LINK) : i.rd;
    endfunction

endpackage

/* hdl/alu.sv */
`include "proc_consts.svh"

module alu (
    input  logic [`WORD_W-1:0]  a_i,
    input  logic [`WORD_W-1:0]  b_i,
    input  proc_pkg::alu_op_e   op_i,
    input  logic [4:0]          shamt_i,
    output logic [`WORD_W-1:0]  result_o
);
    import proc_pkg::*;

    always_comb begin
        case (op_i)
            alu_add: result_o = a_i + b_i;
            alu_sub: result_o = a_i - b_i;
            alu_and: result_o = a_i & b_i;
            alu_or:  result_o = a_i | b_i;
            // shifts act on A only
            alu_sll: result_o = a_i << shamt_i;
            alu_sra: result_o = $signed(a_i) >>> shamt_i;   // keeps sign
            default: result_o = '0;          // unused op codes
        endcase
    end

endmodule

/* hdl/branch_unit.sv */
`include "proc_consts.svh"

module branch_unit (
    input  proc_pkg::opcode_e    op_i,
    input  logic [`WORD_W-1:0]   rd_val_i,
    input  logic [`WORD_W-1:0]   rs_val_i,
    input  logic [`WORD_W-1:0]   pc_i,
    input  logic [`WORD_W-1:0]   imm_i,     // already sign extended
    output proc_pkg::redirect_t  redirect_o
);
    import proc_pkg::*;

    logic not_equal;
    logic less_than;

    assign not_equal = rd_val_i != rs_val_i;
    assign less_than = $signed(rd_val_i) < $signed(rs_val_i);   // rd < rs

    assign redirect_o.valid  = ((op_i == op_bne) && not_equal) ||
                               ((op_i == op_blt) && less_than);
    assign redirect_o.target = pc_i + 1'b1 + imm_i;             // relative to pc + 1

endmodule

/* hdl/fetch_stage.sv */
`include "proc_consts.svh"

module fetch_stage (
    input  logic                 clock_i,
    input  logic                 rst_i,
    input  proc_pkg::instr_t     imem_data_i,
    input  proc_pkg::redirect_t  jr_redirect_i,
    input  proc_pkg::redirect_t  br_redirect_i,
    output logic [`WORD_W-1:0]   imem_addr_o,
    output proc_pkg::fd_t        fd_o
);
    import proc_pkg::*;

    logic [`WORD_W-1:0] pc_q;
    logic [`WORD_W-1:0] pc_plus1;
    logic [`WORD_W-1:0] pc_next;
    logic [`WORD_W-1:0] jump_target;
    logic               is_jump;      // j or jal straight off the imem bus
    logic               flush;        // fetched word is on a dead path

    assign pc_plus1    = pc_q + 1'b1;
    assign jump_target = {{(`WORD_W-`TARGET_W){1'b0}}, imem_data_i[`TARGET_W-1:0]};
    assign is_jump     = (imem_data_i.opcode == op_j) || (imem_data_i.opcode == op_jal);
    assign flush       = br_redirect_i.valid || jr_redirect_i.valid;

    always_comb begin
        if (br_redirect_i.valid) begin           // older instr wins
            pc_next = br_redirect_i.target;
        end else if (jr_redirect_i.valid) begin
            pc_next = jr_redirect_i.target;
        end else if (is_jump) begin              // no bubble for j/jal
            pc_next = jump_target;
        end else begin
            pc_next = pc_plus1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o = pc_q;

    // fetch/decode register
    always_ff @(posedge clock_i) begin
        fd_o.pc   <= pc_q;
        fd_o.link <= pc_plus1;                   // jal return address
        if (rst_i || flush) begin
            fd_o.instr <= '0;                    // nop
        end else begin
            fd_o.instr <= imem_data_i;
        end
    end

endmodule

/* hdl/decode_stage.sv */
`include "proc_consts.svh"

module decode_stage (
    input  logic                    clock_i,
    input  logic                    rst_i,
    input  proc_pkg::fd_t           fd_i,
    input  proc_pkg::redirect_t     br_redirect_i,
    // register file read ports
    output logic [`REG_ADDR_W-1:0]  rf_read_a_o,
    output logic [`REG_ADDR_W-1:0]  rf_read_b_o,
    input  logic [`WORD_W-1:0]      rf_data_a_i,
    input  logic [`WORD_W-1:0]      rf_data_b_i,
    // bypass sources youngest first
    input  proc_pkg::rf_write_t     ex_fwd_i,
    input  proc_pkg::rf_write_t     mem_fwd_i,
    input  proc_pkg::rf_write_t     wb_fwd_i,
    output proc_pkg::redirect_t     jr_redirect_o,
    output proc_pkg::dx_t           dx_o
);
    import proc_pkg::*;

    logic               is_jr;
    logic               is_sw;
    logic               is_branch;
    logic [`WORD_W-1:0] a_val;     // bypassed port A
    logic [`WORD_W-1:0] b_val;     // bypassed port B

    // youngest matching writer wins
    function automatic logic [`WORD_W-1:0] bypass(
        input logic [`REG_ADDR_W-1:0] r,
        input logic [`WORD_W-1:0]     rf_val,
        input rf_write_t              ex,
        input rf_write_t              mem,
        input rf_write_t              wb
    );
        if (ex.we && ex.addr == r) begin
            return ex.data;
        end else if (mem.we && mem.addr == r) begin
            return mem.data;              // load data already merged in
        end else if (wb.we && wb.addr == r) begin
            return wb.data;               // rf write lands at end of cycle
        end
        return rf_val;
    endfunction

    assign is_jr     = fd_i.instr.opcode == op_jr;
    assign is_sw     = fd_i.instr.opcode == op_sw;
    assign is_branch = (fd_i.instr.opcode == op_bne) || (fd_i.instr.opcode == op_blt);

    // port A carries the jr target
    assign rf_read_a_o = is_jr ? fd_i.instr.rd : fd_i.instr.rs;
    // rd is the store data and the branch left operand
    assign rf_read_b_o = (is_sw || is_branch) ? fd_i.instr.rd : fd_i.instr.rt;

    always_comb begin
        a_val = bypass(rf_read_a_o, rf_data_a_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
        b_val = bypass(rf_read_b_o, rf_data_b_i, ex_fwd_i, mem_fwd_i, wb_fwd_i);
    end

    // jr resolves here and costs one bubble
    assign jr_redirect_o.valid  = is_jr;
    assign jr_redirect_o.target = a_val;

    // decode/execute register
    always_ff @(posedge clock_i) begin
        dx_o.pc    <= fd_i.pc;
        dx_o.link  <= fd_i.link;
        dx_o.a_val <= a_val;
        dx_o.b_val <= b_val;
        if (rst_i || br_redirect_i.valid) begin
            dx_o.instr <= '0;              // squash younger instr
        end else begin
            dx_o.instr <= fd_i.instr;
        end
    end

endmodule

/* hdl/execute_stage.sv */
`include "proc_consts.svh"

module execute_stage (
    input  logic                 clock_i,
    input  logic                 rst_i,
    input  proc_pkg::dx_t        dx_i,
    output proc_pkg::rf_write_t  ex_fwd_o,
    output proc_pkg::redirect_t  br_redirect_o,
    output proc_pkg::xm_t        xm_o
);
    import proc_pkg::*;

    logic               use_imm;     // addi and mem address calc
    logic [`WORD_W-1:0] imm;
    logic [`WORD_W-1:0] alu_b;
    alu_op_e            alu_op;
    logic [`WORD_W-1:0] alu_result;
    logic [`WORD_W-1:0] result;

    assign use_imm = (dx_i.instr.opcode == op_addi) || (dx_i.instr.opcode == op_lw) ||
                     (dx_i.instr.opcode == op_sw);
    assign imm     = {{(`WORD_W-`IMM_W){dx_i.instr[`IMM_W-1]}}, dx_i.instr[`IMM_W-1:0]};
    assign alu_b   = use_imm ? imm : dx_i.b_val;
    assign alu_op  = use_imm ? alu_add : alu_op_e'(dx_i.instr.aluop);

    alu u_alu (
        .a_i      (dx_i.a_val),
        .b_i      (alu_b),
        .op_i     (alu_op),
        .shamt_i  (dx_i.instr.shamt),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .op_i       (dx_i.instr.opcode),
        .rd_val_i   (dx_i.b_val),      // port B held rd
        .rs_val_i   (dx_i.a_val),
        .pc_i       (dx_i.pc),
        .imm_i      (imm),
        .redirect_o (br_redirect_o)
    );

    // jal carries its link down the pipe as the result
    assign result = (dx_i.instr.opcode == op_jal) ? dx_i.link : alu_result;

    assign ex_fwd_o.we   = writes_rf(dx_i.instr);
    assign ex_fwd_o.addr = dest_reg(dx_i.instr);
    assign ex_fwd_o.data = result;   // lw address here so load-use is unsupported

    // execute/memory register
    always_ff @(posedge clock_i) begin
        xm_o.result     <= result;
        xm_o.store_data <= dx_i.b_val;
        if (rst_i) begin
            xm_o.instr <= '0;
        end else begin
            xm_o.instr <= dx_i.instr;
        end
    end

endmodule

/* hdl/mem_wb_stage.sv */
`include "proc_consts.svh"

module mem_wb_stage (
    input  logic                 clock_i,
    input  logic                 rst_i,
    input  proc_pkg::xm_t        xm_i,
    input  logic [`WORD_W-1:0]   dmem_data_i,
    output proc_pkg::dmem_req_t  dmem_o,
    output proc_pkg::rf_write_t  mem_fwd_o,
    output proc_pkg::rf_write_t  rf_write_o
);
    import proc_pkg::*;

    logic is_lw;

    assign is_lw = xm_i.instr.opcode == op_lw;

    // data memory request
    assign dmem_o.addr = xm_i.result;             // rs + imm from execute
    assign dmem_o.data = xm_i.store_data;
    assign dmem_o.wren = xm_i.instr.opcode == op_sw;

    // write as it will commit one cycle later
    assign mem_fwd_o.we   = writes_rf(xm_i.instr);
    assign mem_fwd_o.addr = dest_reg(xm_i.instr);  // r31 for jal
    assign mem_fwd_o.data = is_lw ? dmem_data_i : xm_i.result;

    // memory/writeback register drives the rf port directly
    always_ff @(posedge clock_i) begin
        rf_write_o.addr <= mem_fwd_o.addr;
        rf_write_o.data <= mem_fwd_o.data;
        if (rst_i) begin
            rf_write_o.we <= 1'b0;
        end else begin
            rf_write_o.we <= mem_fwd_o.we;
        end
    end

endmodule

/* hdl/proc_top.sv */
`include "proc_consts.svh"

module proc_top (
    input  logic                      clock_i,
    input  logic                      rst_i,
    // instruction memory
    output logic [`WORD_W-1:0]        imem_addr_o,
    input  proc_pkg::instr_t          imem_data_i,
    // data memory
    output proc_pkg::dmem_req_t       dmem_o,
    input  logic [`WORD_W-1:0]        dmem_data_i,
    // register file
    output logic [`REG_ADDR_W-1:0]    rf_read_a_o,
    output logic [`REG_ADDR_W-1:0]    rf_read_b_o,
    input  logic [`WORD_W-1:0]        rf_data_a_i,
    input  logic [`WORD_W-1:0]        rf_data_b_i,
    output proc_pkg::rf_write_t       rf_write_o
);
    import proc_pkg::*;

    fd_t       fd;            // fetch -> decode
    dx_t       dx;            // decode -> execute
    xm_t       xm;            // execute -> memory
    redirect_t jr_redirect;   // from decode
    redirect_t br_redirect;   // from execute, flushes fd and dx
    rf_write_t ex_fwd;
    rf_write_t mem_fwd;

    fetch_stage u_fetch (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .imem_data_i   (imem_data_i),
        .jr_redirect_i (jr_redirect),
        .br_redirect_i (br_redirect),
        .imem_addr_o   (imem_addr_o),
        .fd_o          (fd)
    );

    decode_stage u_decode (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .fd_i          (fd),
        .br_redirect_i (br_redirect),
        .rf_read_a_o   (rf_read_a_o),
        .rf_read_b_o   (rf_read_b_o),
        .rf_data_a_i   (rf_data_a_i),
        .rf_data_b_i   (rf_data_b_i),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_fwd),
        .wb_fwd_i      (rf_write_o),    // writeback port doubles as oldest bypass
        .jr_redirect_o (jr_redirect),
        .dx_o          (dx)
    );

    execute_stage u_execute (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .dx_i          (dx),
        .ex_fwd_o      (ex_fwd),
        .br_redirect_o (br_redirect),
        .xm_o          (xm)
    );

    mem_wb_stage u_mem_wb (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .xm_i        (xm),
        .dmem_data_i (dmem_data_i),
        .dmem_o      (dmem_o),
        .mem_fwd_o   (mem_fwd),
        .rf_write_o  (rf_write_o)
    );

endmodule

/* sim/proc_chk.sv */
`include "proc_consts.svh"

module proc_chk (
    input logic                 clock_i,
    input logic                 rst_i,
    input logic [`WORD_W-1:0]   imem_addr_i,
    input proc_pkg::dmem_req_t  dmem_i,
    input proc_pkg::rf_write_t  rf_write_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // read by the testbench top

    // nothing commits while the first instruction is still in flight
    quiet_after_reset: assert property (@(posedge clock_i)
        $fell(rst_i) |-> (!rf_write_i.we && !dmem_i.wren) [*4])
        else begin fail_count++; $error("commit within four cycles of reset release"); end

    pc_from_reset: assert property (@(posedge clock_i) rst_i |=> imem_addr_i == '0)
        else begin fail_count++; $error("pc not zero after reset"); end

    no_r0_write: assert property (@(posedge clock_i) disable iff (rst_i)
        rf_write_i.we |-> rf_write_i.addr != '0)
        else begin fail_count++; $error("register write aimed at r0"); end

    known_store: assert property (@(posedge clock_i) disable iff (rst_i)
        dmem_i.wren |-> !$isunknown({dmem_i.addr, dmem_i.data}))
        else begin fail_count++; $error("store with unknown address or data"); end

endmodule

bind proc_top proc_chk u_chk (
    .clock_i     (clock_i),
    .rst_i       (rst_i),
    .imem_addr_i (imem_addr_o),
    .dmem_i      (dmem_o),
    .rf_write_i  (rf_write_o)
);

/* sim/proc_checker.sv */
`include "proc_consts.svh"

module proc_checker #(
    parameter int PROG_WORDS = 256
) (
    input  logic                                clock_i,
    input  logic                                rst_i,
    input  logic [PROG_WORDS-1:0][`WORD_W-1:0]  prog_i,
    input  logic [`WORD_W-1:0]                  imem_addr_i,
    input  proc_pkg::rf_write_t                 rf_write_i,
    input  proc_pkg::dmem_req_t                 dmem_i,
    input  logic [31:0][`WORD_W-1:0]            rf_state_i,
    output logic                                done_o,
    output int                                  value_errs_o,
    output int                                  count_errs_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import proc_pkg::*;

    typedef struct packed {
        logic [31:0] next_pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        ld;
        logic        st;
        logic [31:0] maddr;
        logic [31:0] sdata;
    } effect_t;

    logic [36:0] exp_rf [$];      // {reg, data} in program order
    logic [63:0] exp_st [$];      // {addr, data}
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [1024];
    logic [31:0] end_pc = '1;
    logic        ref_ready = 1'b0;
    logic        pc_checked = 1'b0;
    int          rf_seen = 0;
    int          st_seen = 0;
    int          settle = 0;
    int          value_errs = 0;
    int          count_errs = 0;

    assign value_errs_o = value_errs;
    assign count_errs_o = count_errs;

    function automatic logic [31:0] fill_word(int a);
        return (a * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    // architectural effect of one instruction per the ISA rules
    function automatic effect_t ref_step(logic [31:0] w, logic [31:0] pc, logic [31:0] rs_v,
                                         logic [31:0] rt_v, logic [31:0] rd_v);
        effect_t     e;
        logic [31:0] imm;
        imm = {{15{w[16]}}, w[16:0]};
        e = '0;
        e.next_pc = pc + 1;
        e.waddr = w[26:22];
        case (w[31:27])
            op_rtype: begin
                e.we = w[26:22] != 0;
                case (w[6:2])
                    alu_add: e.wdata = rs_v + rt_v;
                    alu_sub: e.wdata = rs_v - rt_v;
                    alu_and: e.wdata = rs_v & rt_v;
                    alu_or:  e.wdata = rs_v | rt_v;
                    alu_sll: e.wdata = rs_v << w[11:7];
                    default: e.wdata = $signed(rs_v) >>> w[11:7];
                endcase
            end
            op_addi: begin
                e.we = w[26:22] != 0;
                e.wdata = rs_v + imm;
            end
            op_lw: begin
                e.we = w[26:22] != 0;
                e.ld = 1'b1;
                e.maddr = rs_v + imm;
            end
            op_sw: begin
                e.st = 1'b1;
                e.maddr = rs_v + imm;
                e.sdata = rd_v;                        // store data comes from rd
            end
            op_bne: if (rd_v != rs_v) e.next_pc = pc + 1 + imm;
            op_blt: if ($signed(rd_v) < $signed(rs_v)) e.next_pc = pc + 1 + imm;
            op_j:   e.next_pc = {5'b0, w[26:0]};
            op_jal: begin
                e.we = 1'b1;
                e.waddr = `REG_LINK;
                e.wdata = pc + 1;
                e.next_pc = {5'b0, w[26:0]};
            end
            op_jr:  e.next_pc = rd_v;
            default: ;
        endcase
        return e;
    endfunction

    task automatic run_reference();
        logic [31:0] pc;
        logic [31:0] w;
        effect_t     e;
        int          steps;
        pc = 0;
        steps = 0;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        for (int a = 0; a < 1024; a++) ref_mem[a] = fill_word(a);
        while (steps < 4 * PROG_WORDS) begin
            w = prog_i[pc[7:0]];
            if (w[31:27] == op_j && w[26:0] == pc[26:0]) begin
                end_pc = pc;                           // reached the self loop
                break;
            end
            e = ref_step(w, pc, ref_regs[w[21:17]], ref_regs[w[16:12]], ref_regs[w[26:22]]);
            if (e.ld) e.wdata = ref_mem[e.maddr[9:0]];
            if (e.we) begin
                ref_regs[e.waddr] = e.wdata;
                exp_rf.push_back({e.waddr, e.wdata});
            end
            if (e.st) begin
                ref_mem[e.maddr[9:0]] = e.sdata;
                exp_st.push_back({e.maddr, e.sdata});
            end
            pc = e.next_pc;
            steps++;
        end
    endtask

    initial begin
        done_o = 1'b0;
        @(negedge rst_i);
        run_reference();
        ref_ready = 1'b1;
    end

    // sampled mid-cycle since every commit is high for exactly one cycle
    always @(negedge clock_i) begin
        if (!rst_i && ref_ready && !done_o) begin
            if (!pc_checked) begin
                pc_checked = 1'b1;
                if (imem_addr_i !== '0) begin
                    value_errs++;
                    $display("error at %0d ns: first fetch address %h, expected 0",
                             $time, imem_addr_i);
                end
            end
            if (rf_write_i.we) begin
                if (rf_seen >= exp_rf.size()) begin
                    count_errs++;
                    $display("extra register write to r%0d at %0d ns", rf_write_i.addr, $time);
                end else if ({rf_write_i.addr, rf_write_i.data} !== exp_rf[rf_seen]) begin
                    value_errs++;
                    $display("error at %0d ns: write %0d is r%0d=%h, expected r%0d=%h", $time,
                             rf_seen, rf_write_i.addr, rf_write_i.data,
                             exp_rf[rf_seen][36:32], exp_rf[rf_seen][31:0]);
                end
                rf_seen++;
            end
            if (dmem_i.wren) begin
                if (st_seen >= exp_st.size()) begin
                    count_errs++;
                    $display("extra store to address %h at %0d ns", dmem_i.addr, $time);
                end else if ({dmem_i.addr, dmem_i.data} !== exp_st[st_seen]) begin
                    value_errs++;
                    $display("error at %0d ns: store %0d is [%h]=%h, expected [%h]=%h", $time,
                             st_seen, dmem_i.addr, dmem_i.data,
                             exp_st[st_seen][63:32], exp_st[st_seen][31:0]);
                end
                st_seen++;
            end
            settle = (imem_addr_i == end_pc) ? settle + 1 : 0;
            if (settle == 10) begin                     // pipeline drained at the loop
                if (rf_seen < exp_rf.size()) begin
                    count_errs++;
                    $display("missing register writes: saw %0d of %0d", rf_seen, exp_rf.size());
                end
                if (st_seen < exp_st.size()) begin
                    count_errs++;
                    $display("missing stores: saw %0d of %0d", st_seen, exp_st.size());
                end
                for (int r = 1; r < 32; r++) begin
                    if (rf_state_i[r] !== ref_regs[r]) begin
                        value_errs++;
                        $display("error at %0d ns: r%0d holds %h, expected %h",
                                 $time, r, rf_state_i[r], ref_regs[r]);
                    end
                end
                done_o = 1'b1;
            end
        end
    end

endmodule

/* sim/proc_tb.sv */
`include "proc_consts.svh"

module proc_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import proc_pkg::*;

    localparam int PROG_WORDS = 256;
    localparam int DMEM_WORDS = 1024;

    logic                                clock = 1'b0;
    logic                                rst = 1'b1;
    logic [`WORD_W-1:0]                  imem_addr;
    instr_t                              imem_data;
    dmem_req_t                           dmem_req;
    logic [`WORD_W-1:0]                  dmem_data;
    logic [`REG_ADDR_W-1:0]              read_a;
    logic [`REG_ADDR_W-1:0]              read_b;
    logic [`WORD_W-1:0]                  rf_a;
    logic [`WORD_W-1:0]                  rf_b;
    rf_write_t                           rf_write;
    logic [PROG_WORDS-1:0][`WORD_W-1:0]  prog = '0;
    logic [31:0][`WORD_W-1:0]            regs = '0;     // register file model
    logic [`WORD_W-1:0]                  dmem [DMEM_WORDS];
    int                                  prog_len = 0;
    int                                  last_rd = 1;   // recent writers for dependences
    int                                  prev_rd = 2;
    logic                                built = 1'b0;
    logic                                done;
    int                                  value_errs;
    int                                  count_errs;

    always #20 clock = ~clock;   // 40 ns period

    // combinational memory and register reads give zero for unknown addresses
    assign imem_data = (!$isunknown(imem_addr) && imem_addr < PROG_WORDS) ?
                       prog[imem_addr[7:0]] : '0;
    assign dmem_data = $isunknown(dmem_req.addr) ? '0 : dmem[dmem_req.addr[9:0]];
    assign rf_a      = ($isunknown(read_a) || read_a == '0) ? '0 : regs[read_a];
    assign rf_b      = ($isunknown(read_b) || read_b == '0) ? '0 : regs[read_b];

    always @(posedge clock) begin
        if (rf_write.we && rf_write.addr != '0) regs[rf_write.addr] <= rf_write.data;
        if (dmem_req.wren) dmem[dmem_req.addr[9:0]] <= dmem_req.data;   // store lands on edge
    end

    proc_top uut (
        .clock_i     (clock),
        .rst_i       (rst),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dmem_o      (dmem_req),
        .dmem_data_i (dmem_data),
        .rf_read_a_o (read_a),
        .rf_read_b_o (read_b),
        .rf_data_a_i (rf_a),
        .rf_data_b_i (rf_b),
        .rf_write_o  (rf_write)
    );

    proc_checker #(.PROG_WORDS(PROG_WORDS)) u_checker (
        .clock_i      (clock),
        .rst_i        (rst),
        .prog_i       (prog),
        .imem_addr_i  (imem_addr),
        .rf_write_i   (rf_write),
        .dmem_i       (dmem_req),
        .rf_state_i   (regs),
        .done_o       (done),
        .value_errs_o (value_errs),
        .count_errs_o (count_errs)
    );

    // initial data memory contents depend on the whole word address
    function automatic logic [`WORD_W-1:0] fill_word(int a);
        return (a * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    function automatic logic [31:0] enc_r(int rd, int rs, int rt, int sh, alu_op_e op);
        return {op_rtype, 5'(rd), 5'(rs), 5'(rt), 5'(sh), op, 2'b00};
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic logic [31:0] enc_j(opcode_e op, int target);
        return {op, 27'(target)};
    endfunction

    task automatic put(logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // mostly the last two writers so every bypass path gets used
    function automatic int pick_src();
        int sel;
        sel = $urandom % 4;
        if (sel == 0) return last_rd;
        if (sel == 1) return prev_rd;
        return 1 + $urandom % 15;
    endfunction

    task automatic gen_alu();
        int rd;
        rd = $urandom % 16;                                // r0 now and then so nothing is written
        if ($urandom % 4 == 0) begin
            put(enc_i(op_addi, rd, pick_src(), int'($urandom % 65536) - 32768));
        end else begin
            put(enc_r(rd, pick_src(), pick_src(), $urandom % 32, alu_op_e'($urandom % 6)));
        end
        prev_rd = last_rd;
        last_rd = rd;
    endtask

    task automatic gen_mem();
        int addr;
        int dst;
        int gap;
        addr = $urandom % 64;
        dst  = 1 + $urandom % 15;
        gap  = (dst % 15) + 1;                              // never dst
        put(enc_i(op_sw, pick_src(), 0, addr));
        put(enc_i(op_lw, dst, 0, addr));
        put(enc_i(op_addi, gap, 0, $urandom % 1000));       // gap before the load use
        put(enc_r(1 + $urandom % 15, dst, pick_src(), 0, alu_add));
        last_rd = dst;
        prev_rd = gap;
    endtask

    task automatic gen_branch();
        int skip;
        skip = 1 + $urandom % 3;
        put(enc_i(($urandom % 2) ? op_bne : op_blt, pick_src(), 1 + $urandom % 15, skip));
        repeat (skip) gen_alu();
    endtask

    task automatic gen_jump();
        int skip;
        skip = 1 + $urandom % 3;
        put(enc_j(op_j, prog_len + 1 + skip));
        repeat (skip) gen_alu();                            // never reached
    endtask

    // j over the subroutine body and its jr r31 to the jal that calls it
    task automatic gen_call();
        int body;
        int entry;
        body  = $urandom % 3;
        entry = prog_len + 1;
        put(enc_j(op_j, entry + body + 1));
        repeat (body) gen_alu();
        put({op_jr, 5'(`REG_LINK), 22'b0});
        put(enc_j(op_jal, entry));
    endtask

    task automatic build_program();
        int kind;
        for (int r = 1; r < 16; r++) put(enc_i(op_addi, r, 0, int'($urandom % 65536) - 32768));
        for (int b = 0; b < 15; b++) begin
            kind = (b < 5) ? b : $urandom % 5;              // each kind at least once
            case (kind)
                0: repeat (3 + $urandom % 3) gen_alu();
                1: gen_mem();
                2: gen_branch();
                3: gen_jump();
                default: gen_call();
            endcase
        end
        put(enc_j(op_j, prog_len));                         // self loop ends the program
    endtask

    initial begin
        void'($urandom(90));
        for (int a = 0; a < DMEM_WORDS; a++) dmem[a] = fill_word(a);
        build_program();
        built = 1'b1;
        repeat (3) @(posedge clock);
        rst <= 1'b0;
    end

    initial begin
        wait (done === 1'b1);
        $display("errors: value %0d, commit count %0d, assertion %0d",
                 value_errs, count_errs, uut.u_chk.fail_count);
        if (value_errs == 0 && count_errs == 0 && uut.u_chk.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog allows five cycles per program word plus slack
    initial begin
        wait (built === 1'b1);
        repeat (5 * prog_len + 50) @(posedge clock);
        $display("timeout: the processor never settled in the final self loop");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hdl/proc_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/proc_top.sv
sim/proc_chk.sv
sim/proc_checker.sv
sim/proc_tb.sv

/* Bender.yml */
package:
  name: proc_pipeline

export_include_dirs:
  - include

sources:
  - hdl/proc_pkg.sv
  - hdl/alu.sv
  - hdl/branch_unit.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/mem_wb_stage.sv
  - hdl/proc_top.sv
  - target: test
    files:
      - sim/proc_chk.sv
      - sim/proc_checker.sv
      - sim/proc_tb.sv
